// ==== scaler_pkg.sv ====
// --------------------------------------------------
// bilinear scaler package
// image sizes, Q16 step ratios and the widths and
// types shared by the down-scaler blocks
// --------------------------------------------------
package scaler_pkg;

    // source and destination image sizes
    localparam int SRC_WIDTH  = 16;
    localparam int SRC_HEIGHT = 12;
    localparam int DST_WIDTH  = 12;
    localparam int DST_HEIGHT = 9;

    // source step per output pixel, floor(src / dst * 2^16)
    localparam logic [16:0] X_RATIO = 17'd87381;
    localparam logic [16:0] Y_RATIO = 17'd87381;

    localparam int FRAC_BITS    = 16;
    localparam int COORD_BITS   = 11;
    localparam int COL_BITS     = 4;
    localparam int NUM_BANKS    = 4;
    localparam int RING_ROWS    = 4;
    localparam int PIPE_LATENCY = 6;

    typedef logic [7:0]                      pixel_t;
    typedef logic [COORD_BITS-1:0]           coord_t;
    typedef logic [COORD_BITS+FRAC_BITS-1:0] acc_t;
    typedef logic [FRAC_BITS:0]              weight_t;
    // row bit 1 on top, column below
    typedef logic [COL_BITS:0]               bank_addr_t;

    // 1.0 in Q16
    localparam weight_t WEIGHT_ONE = weight_t'(1 << FRAC_BITS);

    // datapath widths, Q32 weights and weighted pixels
    typedef logic [2*FRAC_BITS+1:0]  wprod_t;
    typedef logic [2*FRAC_BITS+9:0]  term_t;
    typedef logic [2*FRAC_BITS+10:0] pair_sum_t;
    typedef logic [2*FRAC_BITS+11:0] sum_t;

endpackage

// ==== line_bank.sv ====
// --------------------------------------------------
// line bank
// pixel RAM for two source rows of one parity,
// single write port and registered read
// --------------------------------------------------
`timescale 1ns/10ps

module line_bank
    import scaler_pkg::*;
(
    input  logic       clk_in2,
    input  logic       wr_en,
    input  bank_addr_t wr_addr,
    input  pixel_t     wr_data,
    input  bank_addr_t rd_addr,
    output pixel_t     rd_data
);

    // 32 entries, two rows of 16 pixels
    pixel_t mem [2**$bits(bank_addr_t)];

    always_ff @(posedge clk_in2)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // read data one cycle after the address
    always_ff @(posedge clk_in2)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== pixel_writer.sv ====
// --------------------------------------------------
// pixel writer
// takes the raster pixel stream, writes it into the
// line banks by row parity and reports rows written
// --------------------------------------------------
`timescale 1ns/10ps

module pixel_writer
    import scaler_pkg::*;
(
    input  logic       clk_in2,
    input  logic       rst_n,
    input  logic       pix_valid,
    input  pixel_t     pix_data,
    output logic       pix_ready,
    input  coord_t     row_base,
    input  logic       frame_done,
    output logic       wr_en_even,
    output logic       wr_en_odd,
    output bank_addr_t wr_addr,
    output pixel_t     wr_data,
    output coord_t     rows_done
);

    coord_t col;
    coord_t row;
    logic   xfer;
    logic   frame_full;
    logic   ring_full;
    logic   row_last;

    // whole frame in, hold until the reader is finished with it
    assign frame_full = (row == coord_t'(SRC_HEIGHT));
    // ring holds four rows starting at row_base
    assign ring_full  = ((row - row_base) >= coord_t'(RING_ROWS));
    assign pix_ready  = !frame_full && !ring_full;
    assign xfer       = pix_valid && pix_ready;

    // raster position of the next accepted pixel
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n || frame_done)
        begin
            col <= '0;
            row <= '0;
        end
        else if (xfer)
        begin
            if (col == coord_t'(SRC_WIDTH - 1))
            begin
                col <= '0;
                row <= row + 1'b1;
            end
            else
                col <= col + 1'b1;
        end
    end

    //--------------------------------------------------
    // write stage
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            wr_en_even <= 1'b0;
            wr_en_odd  <= 1'b0;
            row_last   <= 1'b0;
        end
        else
        begin
            wr_en_even <= xfer && !row[0];
            wr_en_odd  <= xfer && row[0];
            row_last   <= xfer && (col == coord_t'(SRC_WIDTH - 1));
        end
    end

    // ring slot from row bit 1
    always_ff @(posedge clk_in2)
    begin
        wr_addr <= {row[1], col[COL_BITS-1:0]};
        wr_data <= pix_data;
    end

    // counts up as each row's last pixel lands
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n || frame_done)
            rows_done <= '0;
        else if (row_last)
            rows_done <= rows_done + 1'b1;
    end

endmodule

// ==== coord_gen.sv ====
// --------------------------------------------------
// coordinate generator
// steps the Q16 source coordinates per frame and
// issues bank reads with fractions and edge flags
// --------------------------------------------------
`timescale 1ns/10ps

module coord_gen
    import scaler_pkg::*;
(
    input  logic       clk_in2,
    input  logic       rst_n,
    input  coord_t     rows_done,
    output coord_t     row_base,
    output logic       frame_done,
    output logic       rd_valid,
    output bank_addr_t rd_addr_even,
    output bank_addr_t rd_addr_odd_col,
    output bank_addr_t rd_addr_odd,
    output bank_addr_t rd_addr_even_col,
    output weight_t    x_frac,
    output weight_t    y_frac,
    output logic       row_parity,
    output logic       edge_right,
    output logic       edge_bottom,
    output logic       sof,
    output logic       eol
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD_Y,
        S_WAIT_ROWS,
        S_EMIT,
        S_NEXT_ROW
    } state_t;

    state_t              state;
    acc_t                x_acc;
    acc_t                y_acc;
    coord_t              x_cnt;
    coord_t              y_cnt;
    coord_t              x_int;
    coord_t              y_int;
    coord_t              y_low;
    logic                last_col;
    logic                last_row;
    logic [COL_BITS-1:0] col_next;
    bank_addr_t          addr_lo;
    bank_addr_t          addr_hi;

    assign x_int    = x_acc[FRAC_BITS +: COORD_BITS];
    assign y_int    = y_acc[FRAC_BITS +: COORD_BITS];
    assign last_col = (x_cnt == coord_t'(DST_WIDTH - 1));
    assign last_row = (y_cnt == coord_t'(DST_HEIGHT - 1));

    //--------------------------------------------------
    // frame FSM
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
            state <= S_IDLE;
        else
        begin
            case (state)
                S_IDLE:
                begin
                    // wait for the first row of the next frame
                    if (!frame_done && rows_done != '0)
                        state <= S_LOAD_Y;
                end
                S_LOAD_Y:
                    state <= S_WAIT_ROWS;
                S_WAIT_ROWS:
                begin
                    if (rows_done > y_low)
                        state <= S_EMIT;
                end
                S_EMIT:
                begin
                    if (last_col)
                        state <= S_NEXT_ROW;
                end
                S_NEXT_ROW:
                    state <= last_row ? S_IDLE : S_LOAD_Y;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // y stepping, row_base doubles as the upper row
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            y_acc      <= '0;
            y_cnt      <= '0;
            row_base   <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            if (state == S_LOAD_Y)
                row_base <= y_int;
            else if (state == S_NEXT_ROW)
            begin
                if (last_row)
                begin
                    y_acc      <= '0;
                    y_cnt      <= '0;
                    row_base   <= '0;
                    frame_done <= 1'b1;
                end
                else
                begin
                    y_acc <= y_acc + Y_RATIO;
                    y_cnt <= y_cnt + 1'b1;
                end
            end
        end
    end

    // lower row clamps to the last source row
    always_ff @(posedge clk_in2)
    begin
        if (state == S_LOAD_Y)
        begin
            y_frac      <= {1'b0, y_acc[FRAC_BITS-1:0]};
            edge_bottom <= (y_int == coord_t'(SRC_HEIGHT - 1));
            y_low       <= (y_int == coord_t'(SRC_HEIGHT - 1)) ? y_int : y_int + 1'b1;
        end
    end

    // x restarts at zero for every row
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n || state != S_EMIT)
        begin
            x_acc <= '0;
            x_cnt <= '0;
        end
        else
        begin
            x_acc <= x_acc + X_RATIO;
            x_cnt <= x_cnt + 1'b1;
        end
    end

    //--------------------------------------------------
    // read issue
    assign rd_valid   = (state == S_EMIT);
    assign x_frac     = {1'b0, x_acc[FRAC_BITS-1:0]};
    assign edge_right = (x_int == coord_t'(SRC_WIDTH - 1));
    assign row_parity = row_base[0];
    assign sof        = rd_valid && (x_cnt == '0) && (y_cnt == '0);
    assign eol        = rd_valid && last_col;

    assign col_next = x_int[COL_BITS-1:0] + 1'b1;
    assign addr_lo  = {row_base[1], x_int[COL_BITS-1:0]};
    assign addr_hi  = {y_low[1], x_int[COL_BITS-1:0]};

    // each parity pair gets the neighbour row of its parity
    assign rd_addr_even     = row_parity ? addr_hi : addr_lo;
    assign rd_addr_odd      = row_parity ? addr_lo : addr_hi;
    assign rd_addr_even_col = {rd_addr_even[COL_BITS], col_next};
    assign rd_addr_odd_col  = {rd_addr_odd[COL_BITS], col_next};

endmodule

// ==== interp_datapath.sv ====
// --------------------------------------------------
// interpolation datapath
// picks the four neighbours, replicates edges, then
// weights, sums, rounds and clamps each output pixel
// --------------------------------------------------
`timescale 1ns/10ps

module interp_datapath
    import scaler_pkg::*;
(
    input  logic    clk_in2,
    input  logic    rst_n,
    input  logic    rd_valid,
    input  pixel_t  bank_data [NUM_BANKS],
    input  weight_t x_frac,
    input  weight_t y_frac,
    input  logic    row_parity,
    input  logic    edge_right,
    input  logic    edge_bottom,
    input  logic    sof,
    input  logic    eol,
    output logic    out_valid,
    output logic    out_sof,
    output logic    out_eol,
    output pixel_t  out_data
);

    weight_t   inv_x;
    weight_t   inv_y;
    wprod_t    w_s1 [4];
    logic      parity_s1;
    logic      right_s1;
    logic      bottom_s1;
    pixel_t    up0;
    pixel_t    up1;
    pixel_t    lo0;
    pixel_t    lo1;
    wprod_t    w_s2 [4];
    pixel_t    pix_s2 [4];
    term_t     term_s3 [4];
    pair_sum_t pair_s4 [2];
    sum_t      sum_s5;
    logic [$bits(sum_t)-2*FRAC_BITS-1:0] rounded;
    logic [PIPE_LATENCY-1:0] valid_sr;
    logic [PIPE_LATENCY-1:0] sof_sr;
    logic [PIPE_LATENCY-1:0] eol_sr;

    //--------------------------------------------------
    // stage 1, weights while the banks read
    assign inv_x = WEIGHT_ONE - x_frac;
    assign inv_y = WEIGHT_ONE - y_frac;

    always_ff @(posedge clk_in2)
    begin
        w_s1[0]   <= inv_x * inv_y;
        w_s1[1]   <= x_frac * inv_y;
        w_s1[2]   <= inv_x * y_frac;
        w_s1[3]   <= x_frac * y_frac;
        parity_s1 <= row_parity;
        right_s1  <= edge_right;
        bottom_s1 <= edge_bottom;
    end

    // bank = parity * 2 + copy
    assign up0 = bank_data[{parity_s1, 1'b0}];
    assign up1 = bank_data[{parity_s1, 1'b1}];
    assign lo0 = bank_data[{!parity_s1, 1'b0}];
    assign lo1 = bank_data[{!parity_s1, 1'b1}];

    // stage 2, neighbour select and edge replication
    always_ff @(posedge clk_in2)
    begin
        pix_s2[0] <= up0;
        pix_s2[1] <= right_s1 ? up0 : up1;
        pix_s2[2] <= bottom_s1 ? up0 : lo0;
        if (bottom_s1)
            pix_s2[3] <= right_s1 ? up0 : up1;
        else
            pix_s2[3] <= right_s1 ? lo0 : lo1;
        w_s2 <= w_s1;
    end

    //--------------------------------------------------
    // stages 3 to 5, products and adder tree
    always_ff @(posedge clk_in2)
    begin
        term_s3[0] <= w_s2[0] * pix_s2[0];
        term_s3[1] <= w_s2[1] * pix_s2[1];
        term_s3[2] <= w_s2[2] * pix_s2[2];
        term_s3[3] <= w_s2[3] * pix_s2[3];
        pair_s4[0] <= term_s3[0] + term_s3[1];
        pair_s4[1] <= term_s3[2] + term_s3[3];
        sum_s5     <= pair_s4[0] + pair_s4[1];
    end

    // stage 6, round at bit 31 and clamp
    assign rounded = sum_s5[$bits(sum_t)-1:2*FRAC_BITS] + sum_s5[2*FRAC_BITS-1];

    always_ff @(posedge clk_in2)
    begin
        out_data <= (rounded > 255) ? 8'd255 : rounded[7:0];
    end

    // valid and tags alongside the data
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            valid_sr <= '0;
            sof_sr   <= '0;
            eol_sr   <= '0;
        end
        else
        begin
            valid_sr <= {valid_sr[PIPE_LATENCY-2:0], rd_valid};
            sof_sr   <= {sof_sr[PIPE_LATENCY-2:0], sof};
            eol_sr   <= {eol_sr[PIPE_LATENCY-2:0], eol};
        end
    end

    assign out_valid = valid_sr[PIPE_LATENCY-1];
    assign out_sof   = sof_sr[PIPE_LATENCY-1];
    assign out_eol   = eol_sr[PIPE_LATENCY-1];

endmodule

// ==== bilinear_scaler_top.sv ====
// --------------------------------------------------
// bilinear scaler top
// writer, four line banks, coordinate generator and
// interpolation datapath on one clock
// --------------------------------------------------
`timescale 1ns/10ps

module bilinear_scaler_top
    import scaler_pkg::*;
(
    input  logic   clk_in2,
    input  logic   rst_n,
    input  logic   pix_valid,
    input  pixel_t pix_data,
    output logic   pix_ready,
    output logic   out_valid,
    output logic   out_sof,
    output logic   out_eol,
    output pixel_t out_data
);

    // write side, enables indexed by row parity
    logic [1:0] bank_wr_en;
    bank_addr_t wr_addr;
    pixel_t     wr_data;
    coord_t     rows_done;
    coord_t     row_base;
    logic       frame_done;

    // read side
    logic       rd_valid;
    bank_addr_t bank_rd_addr [NUM_BANKS];
    pixel_t     bank_rd_data [NUM_BANKS];
    weight_t    x_frac;
    weight_t    y_frac;
    logic       row_parity;
    logic       edge_right;
    logic       edge_bottom;
    logic       rd_sof;
    logic       rd_eol;

    pixel_writer u_writer (
        .clk_in2    (clk_in2),
        .rst_n      (rst_n),
        .pix_valid  (pix_valid),
        .pix_data   (pix_data),
        .pix_ready  (pix_ready),
        .row_base   (row_base),
        .frame_done (frame_done),
        .wr_en_even (bank_wr_en[0]),
        .wr_en_odd  (bank_wr_en[1]),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rows_done  (rows_done)
    );

    //--------------------------------------------------
    // banks, index = parity * 2 + copy
    for (genvar g = 0; g < NUM_BANKS; g++)
    begin : g_bank
        line_bank u_bank (
            .clk_in2 (clk_in2),
            .wr_en   (bank_wr_en[g / 2]),
            .wr_addr (wr_addr),
            .wr_data (wr_data),
            .rd_addr (bank_rd_addr[g]),
            .rd_data (bank_rd_data[g])
        );
    end

    coord_gen u_coord (
        .clk_in2          (clk_in2),
        .rst_n            (rst_n),
        .rows_done        (rows_done),
        .row_base         (row_base),
        .frame_done       (frame_done),
        .rd_valid         (rd_valid),
        .rd_addr_even     (bank_rd_addr[0]),
        .rd_addr_odd_col  (bank_rd_addr[3]),
        .rd_addr_odd      (bank_rd_addr[2]),
        .rd_addr_even_col (bank_rd_addr[1]),
        .x_frac           (x_frac),
        .y_frac           (y_frac),
        .row_parity       (row_parity),
        .edge_right       (edge_right),
        .edge_bottom      (edge_bottom),
        .sof              (rd_sof),
        .eol              (rd_eol)
    );

    interp_datapath u_datapath (
        .clk_in2     (clk_in2),
        .rst_n       (rst_n),
        .rd_valid    (rd_valid),
        .bank_data   (bank_rd_data),
        .x_frac      (x_frac),
        .y_frac      (y_frac),
        .row_parity  (row_parity),
        .edge_right  (edge_right),
        .edge_bottom (edge_bottom),
        .sof         (rd_sof),
        .eol         (rd_eol),
        .out_valid   (out_valid),
        .out_sof     (out_sof),
        .out_eol     (out_eol),
        .out_data    (out_data)
    );

endmodule

// ==== scaler_properties.sv ====
// --------------------------------------------------
// scaler properties
// handshake and pipeline timing checks, bound into
// the scaler top level
// --------------------------------------------------
`timescale 1ns/10ps

module scaler_properties
    import scaler_pkg::*;
(
    input logic       clk_in2,
    input logic       rst_n,
    input logic       pix_valid,
    input logic       pix_ready,
    input logic [1:0] wr_en,
    input logic       rd_valid,
    input logic       out_valid,
    input logic       out_sof,
    input logic       out_eol
);

    // fixed latency from read issue to output beat
    a_latency: assert property (@(posedge clk_in2) disable iff (!rst_n)
        out_valid == $past(rd_valid, PIPE_LATENCY))
    else
        $error("out_valid does not follow rd_valid by the pipeline latency");

    // frame tags only on a valid beat
    a_tags: assert property (@(posedge clk_in2) disable iff (!rst_n)
        (out_sof || out_eol) |-> out_valid)
    else
        $error("out_sof or out_eol high without out_valid");

    // registered write lands one cycle after the transfer
    a_write: assert property (@(posedge clk_in2) disable iff (!rst_n)
        (|wr_en) |-> $past(pix_valid && pix_ready))
    else
        $error("bank write without a pixel handshake");

endmodule

bind bilinear_scaler_top scaler_properties u_props (
    .clk_in2   (clk_in2),
    .rst_n     (rst_n),
    .pix_valid (pix_valid),
    .pix_ready (pix_ready),
    .wr_en     (bank_wr_en),
    .rd_valid  (rd_valid),
    .out_valid (out_valid),
    .out_sof   (out_sof),
    .out_eol   (out_eol)
);

// ==== tb_bilinear_scaler.sv ====
// --------------------------------------------------
// bilinear scaler testbench
// random frames through the scaler, checked against
// a reference model of the bilinear rule
// --------------------------------------------------
`timescale 1ns/10ps

module tb_bilinear_scaler
    import scaler_pkg::*;
();

    localparam int SRC_PIXELS   = SRC_WIDTH * SRC_HEIGHT;
    localparam int DST_PIXELS   = DST_WIDTH * DST_HEIGHT;
    localparam int RESET_CYCLES = 10;
    localparam int TOTAL_FRAMES = 8;
    localparam int CYCLE_LIMIT  = TOTAL_FRAMES * (SRC_PIXELS + DST_PIXELS) * 4 + RESET_CYCLES;
    localparam int FILL_CONST   = 0;
    localparam int FILL_RANDOM  = 1;
    localparam int FILL_CHECKER = 2;

    logic   clk_in2;
    logic   rst_n;
    logic   pix_valid;
    pixel_t pix_data;
    logic   pix_ready;
    logic   out_valid;
    logic   out_sof;
    logic   out_eol;
    pixel_t out_data;

    integer seed;
    int     cycles;
    int     err_cnt;
    int     tests_ok;
    int     tests_bad;
    int     beats;
    int     frame_pos;
    int     test_err0;
    int     test_beats0;
    pixel_t exp_pix;
    pixel_t const_val;
    // up to two source frames held at once
    pixel_t src [2*SRC_PIXELS];
    pixel_t exp_q [$];

    bilinear_scaler_top UUT (
        .clk_in2   (clk_in2),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_ready (pix_ready),
        .out_valid (out_valid),
        .out_sof   (out_sof),
        .out_eol   (out_eol),
        .out_data  (out_data)
    );

    initial
    begin
        clk_in2 = 1'b0;
        forever #20 clk_in2 = ~clk_in2;
    end

    //--------------------------------------------------
    // stimulus and reference model
    task automatic fill_frame(input int f, input int kind, input pixel_t value);
        for (int y = 0; y < SRC_HEIGHT; y++)
            for (int x = 0; x < SRC_WIDTH; x++)
            begin
                if (kind == FILL_CONST)
                    src[f*SRC_PIXELS + y*SRC_WIDTH + x] = value;
                else if (kind == FILL_CHECKER)
                    src[f*SRC_PIXELS + y*SRC_WIDTH + x] = ((x + y) % 2 == 1) ? 8'd255 : 8'd0;
                else
                    src[f*SRC_PIXELS + y*SRC_WIDTH + x] = pixel_t'($random(seed));
            end
    endtask

    // bilinear rule on Q16 positions with Q32 weights
    task automatic push_expected(input int f);
        longint unsigned sx;
        longint unsigned sy;
        longint unsigned fx;
        longint unsigned fy;
        longint unsigned sum;
        int x0;
        int x1;
        int y0;
        int y1;
        int b;
        int res;
        b = f * SRC_PIXELS;
        for (int j = 0; j < DST_HEIGHT; j++)
            for (int i = 0; i < DST_WIDTH; i++)
            begin
                sx  = longint'(i) * longint'(X_RATIO);
                sy  = longint'(j) * longint'(Y_RATIO);
                x0  = int'(sx >> FRAC_BITS);
                y0  = int'(sy >> FRAC_BITS);
                fx  = sx & 64'hFFFF;
                fy  = sy & 64'hFFFF;
                x1  = (x0 == SRC_WIDTH - 1) ? x0 : x0 + 1;
                y1  = (y0 == SRC_HEIGHT - 1) ? y0 : y0 + 1;
                sum = (64'd65536 - fx) * (64'd65536 - fy) * src[b + y0*SRC_WIDTH + x0]
                    + fx * (64'd65536 - fy) * src[b + y0*SRC_WIDTH + x1]
                    + (64'd65536 - fx) * fy * src[b + y1*SRC_WIDTH + x0]
                    + fx * fy * src[b + y1*SRC_WIDTH + x1];
                res = int'(sum >> 32) + int'(sum[31]);
                if (res > 255)
                    res = 255;
                exp_q.push_back(pixel_t'(res));
            end
    endtask

    // source holds the pixel while pix_ready is low
    task automatic send_frame(input int f, input bit gaps);
        int idx;
        bit hold;
        idx  = 0;
        hold = 1'b0;
        while (idx < SRC_PIXELS)
        begin
            @(negedge clk_in2);
            if (!hold)
            begin
                pix_valid = gaps ? (($random(seed) & 3) != 0) : 1'b1;
                pix_data  = pix_valid ? src[f*SRC_PIXELS + idx] : pixel_t'($random(seed));
            end
            hold = pix_valid && !pix_ready;
            if (pix_valid && pix_ready)
                idx++;
        end
        @(negedge clk_in2);
        pix_valid = 1'b0;
        // a full frame blocks the input until the reader finishes it
        if (pix_ready !== 1'b0)
        begin
            $display("ERR %0t ns: pix_ready is %b after a full frame", $time, pix_ready);
            err_cnt++;
        end
    endtask

    task automatic start_test();
        test_err0   = err_cnt;
        test_beats0 = beats;
    endtask

    task automatic finish_test(input string name, input int frames);
        while (exp_q.size() != 0)
            @(posedge clk_in2);
        repeat (PIPE_LATENCY + 4) @(posedge clk_in2);
        if (beats - test_beats0 != frames * DST_PIXELS)
        begin
            $display("%s: received %0d output pixels instead of %0d", name,
                     beats - test_beats0, frames * DST_PIXELS);
            err_cnt++;
        end
        if (err_cnt == test_err0)
        begin
            tests_ok++;
            $display("%s: ok, %0d outputs", name, beats - test_beats0);
        end
        else
        begin
            tests_bad++;
            $display("%s: %0d errors", name, err_cnt - test_err0);
        end
    endtask

    //--------------------------------------------------
    // output monitor on the falling edge
    always @(negedge clk_in2)
    begin
        if (rst_n && out_valid)
        begin
            if (exp_q.size() == 0)
            begin
                $display("an output pixel arrived at %0t ns with none expected", $time);
                err_cnt++;
            end
            else
            begin
                exp_pix = exp_q.pop_front();
                if (out_data !== exp_pix)
                begin
                    $display("ERR %0t ns: pixel %0d expected %0d got %0d",
                             $time, frame_pos, exp_pix, out_data);
                    err_cnt++;
                end
            end
            if (out_sof !== (frame_pos == 0))
            begin
                $display("ERR %0t ns: out_sof is %b at pixel %0d", $time, out_sof, frame_pos);
                err_cnt++;
            end
            if (out_eol !== (frame_pos % DST_WIDTH == DST_WIDTH - 1))
            begin
                $display("ERR %0t ns: out_eol is %b at pixel %0d", $time, out_eol, frame_pos);
                err_cnt++;
            end
            frame_pos = (frame_pos == DST_PIXELS - 1) ? 0 : frame_pos + 1;
            beats++;
        end
    end

    // watchdog
    always @(posedge clk_in2)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles with %0d expected outputs still missing",
                     cycles, exp_q.size());
            $display("Test failed");
            $finish;
        end
    end

    //--------------------------------------------------
    // test sequence
    initial
    begin
        seed      = 78;
        cycles    = 0;
        err_cnt   = 0;
        tests_ok  = 0;
        tests_bad = 0;
        beats     = 0;
        frame_pos = 0;
        rst_n     = 1'b0;
        pix_valid = 1'b0;
        pix_data  = '0;
        repeat (RESET_CYCLES) @(negedge clk_in2);
        rst_n = 1'b1;
        if (pix_ready !== 1'b1)
        begin
            $display("ERR %0t ns: pix_ready is %b after reset", $time, pix_ready);
            err_cnt++;
        end

        start_test();
        const_val = pixel_t'($random(seed));
        fill_frame(0, FILL_CONST, const_val);
        push_expected(0);
        send_frame(0, 1'b0);
        finish_test("constant frame", 1);

        start_test();
        fill_frame(0, FILL_RANDOM, '0);
        push_expected(0);
        send_frame(0, 1'b0);
        finish_test("random frame", 1);

        // full white then 0/255 checkerboard
        start_test();
        fill_frame(0, FILL_CONST, 8'd255);
        fill_frame(1, FILL_CHECKER, '0);
        push_expected(0);
        push_expected(1);
        send_frame(0, 1'b0);
        send_frame(1, 1'b0);
        finish_test("clamp and rounding", 2);

        // second frame meets pix_ready low while the first drains
        start_test();
        fill_frame(0, FILL_RANDOM, '0);
        fill_frame(1, FILL_RANDOM, '0);
        push_expected(0);
        push_expected(1);
        send_frame(0, 1'b1);
        send_frame(1, 1'b1);
        finish_test("input gaps and back-pressure", 2);

        start_test();
        fill_frame(0, FILL_RANDOM, '0);
        fill_frame(1, FILL_RANDOM, '0);
        push_expected(0);
        push_expected(1);
        send_frame(0, 1'b0);
        send_frame(1, 1'b0);
        finish_test("back to back frames", 2);

        $display("summary: %0d tests ok, %0d with errors, %0d outputs checked",
                 tests_ok, tests_bad, beats);
        if (err_cnt == 0 && tests_bad == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== all.f ====
scaler_pkg.sv
line_bank.sv
pixel_writer.sv
coord_gen.sv
interp_datapath.sv
bilinear_scaler_top.sv
scaler_properties.sv
tb_bilinear_scaler.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing --assert -Wno-fatal
TOP        = tb_bilinear_scaler
FILELIST   = all.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation ok"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
